/* common/mem_pkg.sv */
package mem_pkg;

    // ====================================================================
    // Address and data.
    // ====================================================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        ERR_NONE     = 2'd0,
        ERR_MISALIGN = 2'd1,
        ERR_RANGE    = 2'd2
    } mem_err_e;

    // ====================================================================
    // Request and response.
    // ====================================================================
    typedef struct packed {
        logic      valid;
        addr_t     addr;    // Byte address.
        logic      wen;
        data_t     wdata;   // Sits in its byte lanes, as addr[1:0] selects.
        mem_size_e size;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        logic     error;
        mem_err_e err_kind;
        data_t    rdata;    // Whole aligned word.
    } mem_resp_t;

    // Byte lanes touched by an access.
    function automatic logic [3:0] lane_mask(input mem_size_e size, input logic [1:0] offset);
        logic [3:0] mask;
        case (size)
            SIZE_B:  mask = 4'b0001 << offset;
            SIZE_H:  mask = offset[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic logic misaligned(input mem_size_e size, input logic [1:0] offset);
        logic bad;
        case (size)
            SIZE_B:  bad = 1'b0;
            SIZE_H:  bad = offset[0];
            default: bad = |offset;     // Word needs both bits clear.
        endcase
        return bad;
    endfunction

endpackage

/* mem_arbiter/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::mem_req_t  ireq,
    output logic               ireq_ready,
    output mem_pkg::mem_resp_t iresp,
    input  mem_pkg::mem_req_t  dreq,
    output logic               dreq_ready,
    output mem_pkg::mem_resp_t dresp,
    output mem_pkg::mem_req_t  mem_req,
    input  logic               mem_req_ready,
    input  mem_pkg::mem_resp_t mem_resp
);

    typedef enum logic [2:0] {
        I_CHECK,
        I_READY,
        I_VALID,
        D_CHECK,
        D_READY,
        D_VALID
    } state_e;

    state_e            state;
    state_e            state_next;
    mem_pkg::mem_req_t s_ireq;     // Held copy while memory is busy.
    mem_pkg::mem_req_t s_dreq;

    // ====================================================================
    // Controller.
    // ====================================================================
    always_comb begin
        state_next = state;
        case (state)
            I_CHECK: begin
                if (!ireq.valid) begin
                    state_next = D_CHECK;
                end else if (mem_req_ready) begin
                    state_next = I_VALID;
                end else begin
                    state_next = I_READY;
                end
            end
            I_READY: begin
                if (mem_req_ready) begin
                    state_next = I_VALID;
                end
            end
            I_VALID: begin
                if (mem_resp.valid) begin
                    state_next = D_CHECK;
                end
            end
            D_CHECK: begin
                if (!dreq.valid) begin
                    state_next = I_CHECK;
                end else if (mem_req_ready) begin
                    state_next = D_VALID;
                end else begin
                    state_next = D_READY;
                end
            end
            D_READY: begin
                if (mem_req_ready) begin
                    state_next = D_VALID;
                end
            end
            D_VALID: begin
                if (mem_resp.valid) begin
                    state_next = I_CHECK;
                end
            end
            default: state_next = I_CHECK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= I_CHECK;
        end else begin
            state <= state_next;
        end
    end

    // Capture only when memory refuses the live request.
    always_ff @(posedge clk) begin
        if (state == I_CHECK && ireq.valid && !mem_req_ready) begin
            s_ireq <= ireq;
        end
        if (state == D_CHECK && dreq.valid && !mem_req_ready) begin
            s_dreq <= dreq;
        end
    end

    // ====================================================================
    // Request and response routing.
    // ====================================================================
    assign ireq_ready = (state == I_CHECK);
    assign dreq_ready = (state == D_CHECK);

    always_comb begin
        case (state)
            I_CHECK: mem_req = ireq;      // Same-cycle forward.
            I_READY: mem_req = s_ireq;
            D_CHECK: mem_req = dreq;
            D_READY: mem_req = s_dreq;
            default: mem_req = '0;        // Waiting on a response.
        endcase
    end

    always_comb begin
        iresp       = mem_resp;
        iresp.valid = (state == I_VALID) && mem_resp.valid;
        dresp       = mem_resp;
        dresp.valid = (state == D_VALID) && mem_resp.valid;
    end

    // Memory only answers what this controller sent.
    a_no_resp_in_check: assert property (@(posedge clk) disable iff (reset)
        mem_resp.valid |-> !(state inside {I_CHECK, D_CHECK}));

    a_ireq_held: assert property (@(posedge clk) disable iff (reset)
        (state == I_READY) |=> $stable(s_ireq));

    a_dreq_held: assert property (@(posedge clk) disable iff (reset)
        (state == D_READY) |=> $stable(s_dreq));

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {I_CHECK, I_READY, I_VALID, D_CHECK, D_READY, D_VALID});

endmodule

/* mem_store/mem_store.sv */
`timescale 1ns/1ps

module mem_store #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::mem_req_t  req,
    output logic               req_ready,
    output mem_pkg::mem_resp_t resp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(MEM_LATENCY - 1);

    mem_pkg::data_t mem [MEM_WORDS];

    logic              busy;
    logic [CNT_W-1:0]  cnt;          // Cycles left before the response.
    logic              accept;
    logic [29:0]       word_idx;
    logic [IDX_W-1:0]  mem_idx;
    logic [3:0]        lanes;
    logic [31:0]       bit_mask;
    mem_pkg::mem_err_e err_kind;
    mem_pkg::data_t    old_word;
    mem_pkg::data_t    new_word;
    mem_pkg::mem_err_e err_q;
    mem_pkg::data_t    rdata_q;

    assign req_ready = !busy;
    assign accept    = req.valid && req_ready;

    // ====================================================================
    // Access decode.
    // ====================================================================
    assign word_idx = req.addr[31:2];
    assign mem_idx  = word_idx[IDX_W-1:0];
    assign lanes    = mem_pkg::lane_mask(req.size, req.addr[1:0]);

    // Alignment is checked before range.
    always_comb begin
        if (mem_pkg::misaligned(req.size, req.addr[1:0])) begin
            err_kind = mem_pkg::ERR_MISALIGN;
        end else if (word_idx >= 30'(MEM_WORDS)) begin
            err_kind = mem_pkg::ERR_RANGE;
        end else begin
            err_kind = mem_pkg::ERR_NONE;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            bit_mask[8*i +: 8] = {8{lanes[i]}};
        end
    end

    assign old_word = mem[mem_idx];
    assign new_word = (old_word & ~bit_mask) | (req.wdata & bit_mask);

    // ====================================================================
    // Storage and response.
    // ====================================================================
    always_ff @(posedge clk) begin
        if (accept && req.wen && err_kind == mem_pkg::ERR_NONE) begin
            mem[mem_idx] <= new_word;
        end
    end

    // Old word goes back, also on a write.
    always_ff @(posedge clk) begin
        if (accept) begin
            err_q   <= err_kind;
            rdata_q <= (err_kind == mem_pkg::ERR_NONE) ? old_word : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= CNT_LOAD;
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;        // Ready again after the response.
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign resp.valid    = busy && (cnt == '0);
    assign resp.error    = (err_q != mem_pkg::ERR_NONE);
    assign resp.err_kind = err_q;
    assign resp.rdata    = rdata_q;

    a_no_accept_busy: assert property (@(posedge clk) disable iff (reset)
        accept |=> !accept [*MEM_LATENCY]);

    a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        resp.valid |=> !resp.valid);

endmodule

/* verilog/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3     // At least 1.
) (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::mem_req_t  ireq,
    output logic               ireq_ready,
    output mem_pkg::mem_resp_t iresp,
    input  mem_pkg::mem_req_t  dreq,
    output logic               dreq_ready,
    output mem_pkg::mem_resp_t dresp
);

    mem_pkg::mem_req_t  mem_req;
    logic               mem_req_ready;
    mem_pkg::mem_resp_t mem_resp;

    // ====================================================================
    // Port arbiter and shared memory.
    // ====================================================================
    mem_arbiter arb (
        .clk           (clk),
        .reset         (reset),
        .ireq          (ireq),
        .ireq_ready    (ireq_ready),
        .iresp         (iresp),
        .dreq          (dreq),
        .dreq_ready    (dreq_ready),
        .dresp         (dresp),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_resp      (mem_resp)
    );

    mem_store #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) store (
        .clk       (clk),
        .reset     (reset),
        .req       (mem_req),
        .req_ready (mem_req_ready),
        .resp      (mem_resp)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Released on a rising edge, so the DUT still sees it high there.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int WAIT_LIMIT  = 40;    // Cycles per wait.

    typedef struct packed {
        mem_pkg::mem_resp_t resp;
        mem_pkg::data_t     care;       // Bits of rdata with known value.
        int                 cyc;        // Cycle of acceptance.
    } pend_t;

    logic               clk;
    logic               reset;
    mem_pkg::mem_req_t  ireq;
    mem_pkg::mem_req_t  dreq;
    logic               ireq_ready;
    logic               dreq_ready;
    mem_pkg::mem_resp_t iresp;
    mem_pkg::mem_resp_t dresp;

    mem_pkg::data_t    ref_mem [MEM_WORDS];
    mem_pkg::data_t    known_bits [MEM_WORDS];
    pend_t             pend_i[$];
    pend_t             pend_d[$];
    logic              order_q[$];      // Port of each accepted request.
    mem_pkg::mem_req_t ilist[$];
    mem_pkg::mem_req_t dlist[$];
    integer            seed;
    int                cyc;
    int                issued;
    int                resp_count;
    logic              alt_mode;
    logic              alt_next;

    tb_clock #(.PERIOD(4.0), .RESET_CYCLES(2)) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mem_subsys #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .ireq       (ireq),
        .ireq_ready (ireq_ready),
        .iresp      (iresp),
        .dreq       (dreq),
        .dreq_ready (dreq_ready),
        .dresp      (dresp)
    );

    // ====================================================================
    // Reference model.
    // ====================================================================
    function automatic mem_pkg::mem_resp_t ref_access(input mem_pkg::mem_req_t r,
                                                      output mem_pkg::data_t care);
        mem_pkg::mem_resp_t res;
        logic [29:0]        idx;
        mem_pkg::data_t     bm;
        res       = '0;
        res.valid = 1'b1;
        idx       = r.addr[31:2];
        care      = '1;
        case (r.size)
            mem_pkg::SIZE_B: bm = 32'h0000_00ff << (8 * r.addr[1:0]);
            mem_pkg::SIZE_H: bm = r.addr[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:         bm = 32'hffff_ffff;
        endcase
        if ((r.size == mem_pkg::SIZE_H && r.addr[0]) ||
            (r.size == mem_pkg::SIZE_W && r.addr[1:0] != 2'b00)) begin
            res.error    = 1'b1;
            res.err_kind = mem_pkg::ERR_MISALIGN;
        end else if (idx >= MEM_WORDS) begin
            res.error    = 1'b1;
            res.err_kind = mem_pkg::ERR_RANGE;
        end else begin
            res.rdata = ref_mem[idx];           // Old word, also on a write.
            care      = known_bits[idx];
            if (r.wen) begin
                ref_mem[idx]    = (ref_mem[idx] & ~bm) | (r.wdata & bm);
                known_bits[idx] = known_bits[idx] | bm;
            end
        end
        return res;
    endfunction

    function automatic mem_pkg::mem_req_t make_req(input logic wen, input mem_pkg::addr_t addr,
                                                   input mem_pkg::data_t wdata,
                                                   input mem_pkg::mem_size_e size);
        mem_pkg::mem_req_t r;
        r.valid = 1'b1;
        r.wen   = wen;
        r.addr  = addr;
        r.wdata = wdata;
        r.size  = size;
        return r;
    endfunction

    function automatic mem_pkg::mem_req_t rand_req();
        logic [31:0] word;
        logic [31:0] pick;
        mem_pkg::mem_req_t r;
        word    = $unsigned($random(seed)) % (MEM_WORDS + 8);  // Some beyond range.
        pick    = $unsigned($random(seed));
        r.valid = 1'b1;
        r.wen   = pick[8];
        r.addr  = (word << 2) | {30'd0, pick[1:0]};
        r.size  = mem_pkg::mem_size_e'(pick[5:4] == 2'd3 ? 2'd2 : pick[5:4]);
        r.wdata = $random(seed);
        return r;
    endfunction

    // ====================================================================
    // Compare tasks.
    // ====================================================================
    task automatic stop_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_resp(input mem_pkg::mem_resp_t exp, input mem_pkg::mem_resp_t act,
                              input mem_pkg::data_t care);
        if (act.error !== exp.error || act.err_kind !== exp.err_kind ||
            (act.rdata & care) !== (exp.rdata & care)) begin
            $display("[ERROR] %0t: response expected err=%0b kind=%0d rdata=%h, got %0b %0d %h",
                     $time, exp.error, exp.err_kind, exp.rdata & care,
                     act.error, act.err_kind, act.rdata & care);
            stop_run("response mismatch");
        end
    endtask

    task automatic check_port_order(input logic exp_port, input logic act_port);
        if (exp_port !== act_port) begin
            $display("[ERROR] %0t: response expected on port %s, arrived on port %s",
                     $time, exp_port ? "D" : "I", act_port ? "D" : "I");
            stop_run("response order mismatch");
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %0t: latency expected %0d cycles, got %0d", $time, exp, act);
            stop_run("latency mismatch");
        end
    endtask

    task automatic check_bit(input logic exp, input logic act, input string what);
        if (exp !== act) begin
            $display("[ERROR] %0t: %s expected %0b, got %0b", $time, what, exp, act);
            stop_run("signal mismatch");
        end
    endtask

    // ====================================================================
    // Client and monitor.
    // ====================================================================
    task automatic issue(input logic port, input mem_pkg::mem_req_t r);
        int waited;
        issued++;
        @(posedge clk);
        if (port) dreq <= r;
        else ireq <= r;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run(port ? "timeout waiting for dreq_ready" : "timeout waiting for ireq_ready");
            end
        end while (!(port ? dreq_ready : ireq_ready));
        @(posedge clk);
        if (port) dreq <= '0;
        else ireq <= '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run(port ? "timeout waiting for dresp" : "timeout waiting for iresp");
            end
        end while (!(port ? dresp.valid : iresp.valid));
    endtask

    task automatic take_resp(input logic port, input mem_pkg::mem_resp_t act);
        pend_t p;
        if ((port && pend_d.size() == 0) || (!port && pend_i.size() == 0)) begin
            stop_run("response arrived with no request outstanding");
        end
        if (port) p = pend_d.pop_front();
        else p = pend_i.pop_front();
        check_port_order(order_q.pop_front(), port);
        if (alt_mode) begin
            check_port_order(alt_next, port);
            alt_next = !alt_next;
        end
        check_resp(p.resp, act, p.care);
        check_latency(MEM_LATENCY, cyc - p.cyc);
        resp_count++;
    endtask

    // Sampled mid-cycle, where everything is settled.
    always @(negedge clk) begin
        pend_t          p;
        mem_pkg::data_t care;
        cyc = cyc + 1;
        if (!reset) begin
            if (ireq_ready && ireq.valid) begin
                p.resp = ref_access(ireq, care);
                p.care = care;
                p.cyc  = cyc;
                pend_i.push_back(p);
                order_q.push_back(1'b0);
            end
            if (dreq_ready && dreq.valid) begin
                p.resp = ref_access(dreq, care);
                p.care = care;
                p.cyc  = cyc;
                pend_d.push_back(p);
                order_q.push_back(1'b1);
            end
            if (iresp.valid) take_resp(1'b0, iresp);
            if (dresp.valid) take_resp(1'b1, dresp);
        end
    end

    // ====================================================================
    // Stimulus.
    // ====================================================================
    initial begin
        int waited;
        seed       = 32'h0fe1_21f4;
        ireq       = '0;
        dreq       = '0;
        cyc        = 0;
        issued     = 0;
        resp_count = 0;
        alt_mode   = 1'b0;
        alt_next   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]    = '0;
            known_bits[i] = '0;     // Memory is not reset.
        end

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20) stop_run("reset was never released");
        end while (reset);

        // Idle controller polls I and D in turn.
        for (int k = 0; k < 10; k++) begin
            check_bit(k % 2 == 0, ireq_ready, "ireq_ready while idle");
            check_bit(k % 2 == 1, dreq_ready, "dreq_ready while idle");
            check_bit(1'b0, iresp.valid, "iresp.valid while idle");
            check_bit(1'b0, dresp.valid, "dresp.valid while idle");
            @(negedge clk);
        end

        // Start both clients so that I_CHECK comes next.
        waited = 0;
        while (ireq_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) stop_run("timeout waiting for D_CHECK");
        end
        alt_mode = 1'b1;
        alt_next = 1'b0;
        fork
            for (int n = 0; n < 4; n++) begin
                issue(1'b0, make_req(1'b0, 32'h40 + 4 * n, '0, mem_pkg::SIZE_W));
            end
            for (int n = 0; n < 4; n++) begin
                issue(1'b1, make_req(1'b1, 32'h80 + 4 * n, 32'h1111_0000 + n, mem_pkg::SIZE_W));
            end
        join
        alt_mode = 1'b0;

        // Word write, then read from the other port.
        issue(1'b1, make_req(1'b1, 32'h100, 32'h1234_5678, mem_pkg::SIZE_W));
        issue(1'b1, make_req(1'b1, 32'h100, 32'hcafe_f00d, mem_pkg::SIZE_W));
        issue(1'b0, make_req(1'b0, 32'h100, '0, mem_pkg::SIZE_W));

        issue(1'b1, make_req(1'b1, 32'h101, 32'h0000_ab00, mem_pkg::SIZE_B));
        issue(1'b1, make_req(1'b1, 32'h102, 32'h5a5a_0000, mem_pkg::SIZE_H));
        issue(1'b1, make_req(1'b1, 32'h100, 32'h0000_0011, mem_pkg::SIZE_B));
        issue(1'b0, make_req(1'b0, 32'h100, '0, mem_pkg::SIZE_W));

        // Faulting accesses leave the word alone.
        issue(1'b1, make_req(1'b1, 32'h104, 32'h0bad_beef, mem_pkg::SIZE_W));
        issue(1'b1, make_req(1'b1, 32'h105, 32'hffff_ffff, mem_pkg::SIZE_H));
        issue(1'b1, make_req(1'b1, 32'h106, 32'hffff_ffff, mem_pkg::SIZE_W));
        issue(1'b0, make_req(1'b0, MEM_WORDS * 4, '0, mem_pkg::SIZE_W));
        // Low index bits alias 0x104.
        issue(1'b1, make_req(1'b1, MEM_WORDS * 4 + 32'h105, 32'hffff_ffff, mem_pkg::SIZE_B));
        issue(1'b0, make_req(1'b0, MEM_WORDS * 4 + 2, '0, mem_pkg::SIZE_W));
        issue(1'b0, make_req(1'b0, 32'h104, '0, mem_pkg::SIZE_W));

        for (int n = 0; n < 100; n++) begin
            ilist.push_back(rand_req());
            dlist.push_back(rand_req());
        end
        fork
            for (int n = 0; n < 100; n++) issue(1'b0, ilist[n]);
            for (int n = 0; n < 100; n++) issue(1'b1, dlist[n]);
        join

        @(negedge clk);
        if (resp_count == issued && pend_i.size() == 0 && pend_d.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "%0d requests issued but %0d responses checked", issued, resp_count);
        end
    end

endmodule

/* list.f */
common/mem_pkg.sv
mem_arbiter/mem_arbiter.sv
mem_store/mem_store.sv
verilog/mem_subsys.sv
tests/tb_clock.sv
tests/tb_mem_subsys.sv

/* Makefile */
# Verilator build for the memory subsystem testbench.

SIM      = verilator
TOP      = tb_mem_subsys
FILELIST = list.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  = obj_dir

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a failing exit status.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
